/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module rv32Core_tb -f filelist.f -o Vrv32Core_tb
	./obj_dir/Vrv32Core_tb | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "Simulation ended without a pass report"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* common/rv32Core_pkg.sv */
package rv32Core_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIndex_t;
	typedef logic [15:0] mgmtAddress_t;

	typedef enum logic {
		STATE_HALT = 1'b0,
		STATE_EXECUTE = 1'b1
	} coreState_t;

	// Base opcodes of the RV32I subset
	typedef enum logic [6:0] {
		OPCODE_OP_IMM = 7'b0010011,
		OPCODE_OP = 7'b0110011,
		OPCODE_LUI = 7'b0110111
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} aluOp_t;

	// Address bits 15:14
	typedef enum logic [1:0] {
		REGION_SYSTEM = 2'b00,
		REGION_REGISTERS = 2'b01
	} mgmtRegion_t;

	localparam mgmtAddress_t MGMT_PC_SET = 16'h0000;
	localparam mgmtAddress_t MGMT_PC_STEP = 16'h0008;
	localparam mgmtAddress_t MGMT_INSTRUCTION = 16'h0010;
	// Register n at base + 4*n
	localparam mgmtAddress_t MGMT_REGISTER_BASE = 16'h4000;

	localparam word_t MGMT_UNMAPPED = 32'hFFFF_FFFF;

	// ADDI x0, x0, 0
	localparam word_t NOP_INSTRUCTION = 32'h0000_0013;

endpackage

/* dv/rv32Core_checker.sv */
`timescale 1ns/10ps

module rv32Core_checker (
	input logic clk,
	input logic rst,
	input logic instructionEnable,
	input logic instructionBusy,
	input rv32Core_pkg::word_t instructionAddress,
	input logic retire
);
	int failureCount = 0;

	// No fetch in the first cycle out of reset
	enableLowAfterReset: assert property (@(posedge clk) rst |=> !instructionEnable)
	else begin
		failureCount++;
		$error("instructionEnable high in the cycle after reset");
	end

	addressHeldWhileBusy: assert property (@(posedge clk) disable iff (rst)
		(instructionEnable && instructionBusy) |=> (instructionEnable && $stable(instructionAddress)))
	else begin
		failureCount++;
		$error("fetch request changed while instruction memory was busy");
	end

	retireSingleCycle: assert property (@(posedge clk) disable iff (rst) retire |=> !retire)
	else begin
		failureCount++;
		$error("retire high on two cycles in a row");
	end

endmodule

bind fetchControl rv32Core_checker fetchChecker0 (
	.clk(clk),
	.rst(rst),
	.instructionEnable(instructionEnable),
	.instructionBusy(instructionBusy),
	.instructionAddress(instructionAddress),
	.retire(retire)
);

/* dv/rv32Core_tb.sv */
`timescale 1ns/10ps

module rv32Core_tb;
	import rv32Core_pkg::*;

	localparam word_t RESET_VECTOR = 32'h0000_0200;
	localparam word_t TABLE_BASE = 32'h0000_0080;
	localparam int NUM_ENTRIES = 21;
	localparam int PROGRAM_LENGTH = 6;
	localparam int ENTRY_CYCLES = 60;
	// Table entries plus a few entries' worth for the other tests
	localparam int WATCHDOG_CYCLES = (NUM_ENTRIES + 4) * ENTRY_CYCLES;

	logic clk;
	logic rst;
	logic run;
	logic writeEnable;
	logic [3:0] byteSelect;
	mgmtAddress_t address;
	word_t writeData;
	word_t readData;
	word_t instructionAddress;
	logic instructionEnable;
	word_t instructionDataRead;
	logic instructionBusy;
	coreState_t probeState;
	word_t probeProgramCounter;

	integer seed = 27;
	word_t instructionMemory [0:63];
	word_t modelRegisters [0:31];

	// Columns: instruction, rs1 (x1), rs2 (x2), expected rd
	logic [127:0] stimulus [0:NUM_ENTRIES-1] = '{
		{32'hFFB0_8193, 32'h0000_0010, 32'h0000_0000, 32'h0000_000B},
		{32'h0010_A193, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0001},
		{32'h0010_B193, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0000},
		{32'h0FF0_C193, 32'h1234_5678, 32'h0000_0000, 32'h1234_5687},
		{32'hFF00_E193, 32'h0000_0005, 32'h0000_0000, 32'hFFFF_FFF5},
		{32'h7F00_F193, 32'h1234_5678, 32'h0000_0000, 32'h0000_0670},
		{32'h0040_9193, 32'h8000_000F, 32'h0000_0000, 32'h0000_00F0},
		{32'h0040_D193, 32'h8000_0000, 32'h0000_0000, 32'h0800_0000},
		{32'h4040_D193, 32'h8000_0000, 32'h0000_0000, 32'hF800_0000},
		{32'h0020_81B3, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000},
		{32'h4020_81B3, 32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE},
		{32'h0020_91B3, 32'h0000_0001, 32'h0000_0023, 32'h0000_0008},
		{32'h0020_A1B3, 32'h8000_0000, 32'h0000_0001, 32'h0000_0001},
		{32'h0020_B1B3, 32'h8000_0000, 32'h0000_0001, 32'h0000_0000},
		{32'h0020_C1B3, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'h0FF0_0FF0},
		{32'h0020_D1B3, 32'hF000_0000, 32'h0000_0008, 32'h00F0_0000},
		{32'h4020_D1B3, 32'hF000_0000, 32'h0000_0008, 32'hFFF0_0000},
		{32'h0020_E1B3, 32'h0000_FF00, 32'h00FF_0000, 32'h00FF_FF00},
		{32'h0020_F1B3, 32'hFF00_FF00, 32'h0FF0_0FF0, 32'h0F00_0F00},
		{32'hABCD_E1B7, 32'h0000_0000, 32'h0000_0000, 32'hABCD_E000},
		{32'h0000_0013, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000}
	};

	// ADDI x1, ADDI x2, ADD x3, SLLI x4, SUB x5, LUI x6
	word_t programWords [0:PROGRAM_LENGTH-1] = '{
		32'h0640_0093, 32'hFFD0_0113, 32'h0020_81B3,
		32'h0021_9213, 32'h4041_02B3, 32'h1234_5337
	};

	rv32Core #(.resetVector(RESET_VECTOR)) dut0 (.*);

	assign instructionDataRead = instructionMemory[instructionAddress[7:2]];

	always #2 clk = ~clk;

	always @(negedge clk) begin
		instructionBusy = ($random(seed) & 3) == 0;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkWord(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			failRun($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic checkState(input string name, input coreState_t actual,
		input coreState_t expected);
		if (actual !== expected) begin
			failRun($sformatf("FAIL %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	function automatic mgmtAddress_t registerAddress(input int index);
		return 16'h4000 + mgmtAddress_t'(4 * index);
	endfunction

	function automatic word_t maskBytes(input word_t data, input logic [3:0] sel);
		word_t masked;
		masked = '0;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				masked[8*i +: 8] = data[8*i +: 8];
			end
		end
		return masked;
	endfunction

	// RV32I semantics of the supported subset
	function automatic word_t modelResult(input word_t instr, input word_t a, input word_t b);
		word_t operand;
		logic [4:0] shamt;
		operand = instr[5] ? b : {{20{instr[31]}}, instr[31:20]};
		shamt = operand[4:0];
		if (instr[6:0] == 7'b0110111) begin
			return {instr[31:12], 12'h000};
		end
		case (instr[14:12])
			3'd0: return (instr[5] && instr[30]) ? a - operand : a + operand;
			3'd1: return a << shamt;
			3'd2: return ($signed(a) < $signed(operand)) ? 32'd1 : 32'd0;
			3'd3: return (a < operand) ? 32'd1 : 32'd0;
			3'd4: return a ^ operand;
			3'd5: return instr[30] ? word_t'($signed(a) >>> shamt) : a >> shamt;
			3'd6: return a | operand;
			default: return a & operand;
		endcase
	endfunction

	task automatic writeManagement(input mgmtAddress_t addr, input word_t data);
		@(negedge clk);
		writeEnable = 1'b1;
		address = addr;
		writeData = data;
		byteSelect = 4'hF;
		@(negedge clk);
		writeEnable = 1'b0;
	endtask

	task automatic readManagement(input mgmtAddress_t addr, input logic [3:0] sel,
		output word_t data);
		@(negedge clk);
		writeEnable = 1'b0;
		address = addr;
		byteSelect = sel;
		#1;
		data = readData;
	endtask

	// Step ends when the PC read-back moves on by one instruction
	task automatic stepAndWait(input word_t startPc);
		word_t pc;
		int cycles;
		writeManagement(MGMT_PC_STEP, '0);
		cycles = 0;
		readManagement(MGMT_PC_SET, 4'hF, pc);
		while (pc !== startPc + 32'd4) begin
			cycles++;
			if (cycles > ENTRY_CYCLES) begin
				failRun($sformatf("Step from PC %h did not retire in time", startPc));
			end
			readManagement(MGMT_PC_SET, 4'hF, pc);
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		failRun("Watchdog expired before the tests completed");
	end

	initial begin
		word_t value;
		word_t instr;
		word_t rs1Value;
		word_t rs2Value;
		word_t expected;
		word_t pc;
		word_t saved [1:3];
		clk = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		writeEnable = 1'b0;
		byteSelect = 4'hF;
		address = '0;
		writeData = '0;
		instructionBusy = 1'b0;
		for (int i = 0; i < 64; i++) begin
			instructionMemory[i] = NOP_INSTRUCTION;
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;

		readManagement(MGMT_PC_SET, 4'hF, value);
		checkWord("readData", value, RESET_VECTOR);
		checkState("probeState", probeState, STATE_HALT);
		readManagement(16'h0004, 4'hF, value);
		checkWord("readData", value, 32'hFFFF_FFFF);
		readManagement(16'h8000, 4'hF, value);
		checkWord("readData", value, 32'hFFFF_FFFF);

		writeManagement(registerAddress(5), 32'hA5C3_1E7F);
		for (int sel = 0; sel < 16; sel += 5) begin
			readManagement(registerAddress(5), sel[3:0], value);
			checkWord("readData", value, maskBytes(32'hA5C3_1E7F, sel[3:0]));
		end
		writeManagement(registerAddress(0), 32'hFFFF_FFFF);
		readManagement(registerAddress(0), 4'hF, value);
		checkWord("x0", value, 32'h0000_0000);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			{instr, rs1Value, rs2Value, expected} = stimulus[i];
			pc = TABLE_BASE + word_t'(4 * i);
			instructionMemory[pc[7:2]] = instr;
			writeManagement(registerAddress(1), rs1Value);
			writeManagement(registerAddress(2), rs2Value);
			writeManagement(MGMT_PC_SET, pc);
			stepAndWait(pc);
			checkState("probeState", probeState, STATE_HALT);
			checkWord("probeProgramCounter", probeProgramCounter, pc + 32'd4);
			checkWord("model", modelResult(instr, rs1Value, rs2Value), expected);
			readManagement(registerAddress(int'(instr[11:7])), 4'hF, value);
			checkWord($sformatf("x%0d", instr[11:7]), value, expected);
			readManagement(MGMT_INSTRUCTION, 4'hF, value);
			checkWord("instruction", value, instr);
		end

		// MUL is outside the subset
		pc = TABLE_BASE + word_t'(4 * NUM_ENTRIES);
		instructionMemory[pc[7:2]] = 32'h0220_81B3;
		writeManagement(registerAddress(3), 32'h1357_9BDF);
		for (int r = 1; r <= 3; r++) begin
			readManagement(registerAddress(r), 4'hF, saved[r]);
		end
		writeManagement(MGMT_PC_SET, pc);
		stepAndWait(pc);
		for (int r = 1; r <= 3; r++) begin
			readManagement(registerAddress(r), 4'hF, value);
			checkWord($sformatf("x%0d", r), value, saved[r]);
		end

		for (int r = 0; r < 32; r++) begin
			modelRegisters[r] = '0;
		end
		for (int i = 0; i < PROGRAM_LENGTH; i++) begin
			instr = programWords[i];
			instructionMemory[i] = instr;
			value = modelResult(instr, modelRegisters[instr[19:15]],
				modelRegisters[instr[24:20]]);
			if (instr[11:7] != 5'd0) begin
				modelRegisters[instr[11:7]] = value;
			end
		end
		writeManagement(MGMT_PC_SET, 32'h0000_0000);
		@(negedge clk);
		run = 1'b1;
		while (probeProgramCounter < word_t'(4 * PROGRAM_LENGTH)) begin
			@(negedge clk);
		end
		run = 1'b0;
		while (probeState !== STATE_HALT) begin
			@(negedge clk);
		end
		for (int r = 1; r <= PROGRAM_LENGTH; r++) begin
			readManagement(registerAddress(r), 4'hF, value);
			checkWord($sformatf("x%0d", r), value, modelRegisters[r]);
		end

		if (dut0.fetchControl0.fetchChecker0.failureCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("Fetch checker assertions failed during the run");
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* execute/instructionDecoder.sv */
`timescale 1ns/10ps

module instructionDecoder (
	input rv32Core_pkg::word_t instruction,
	input rv32Core_pkg::word_t rs1Data,
	input rv32Core_pkg::word_t rs2Data,
	output rv32Core_pkg::regIndex_t rs1Index,
	output rv32Core_pkg::regIndex_t rs2Index,
	output rv32Core_pkg::regIndex_t rdIndex,
	output logic rdWrite,
	output rv32Core_pkg::aluOp_t aluOp,
	output rv32Core_pkg::word_t operandA,
	output rv32Core_pkg::word_t operandB
);
	import rv32Core_pkg::*;

	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic funct7Valid;
	word_t immediateI;
	word_t immediateU;

	assign opcode = opcode_t'(instruction[6:0]);
	assign rdIndex = instruction[11:7];
	assign funct3 = instruction[14:12];
	assign rs1Index = instruction[19:15];
	assign rs2Index = instruction[24:20];
	assign funct7 = instruction[31:25];

	// Only base and alternate encodings, M extension falls through as a no-op
	assign funct7Valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

	assign immediateI = {{20{instruction[31]}}, instruction[31:20]};
	assign immediateU = {instruction[31:12], 12'b0};

	always_comb begin
		aluOp = ALU_ADD;
		operandA = rs1Data;
		operandB = rs2Data;
		rdWrite = 1'b0;
		case (opcode)
			OPCODE_OP_IMM: begin
				operandB = immediateI;
				rdWrite = 1'b1;
				case (funct3)
					3'b000: aluOp = ALU_ADD;
					3'b001: begin
						aluOp = ALU_SLL;
						rdWrite = funct7 == 7'b0000000;
					end
					3'b010: aluOp = ALU_SLT;
					3'b011: aluOp = ALU_SLTU;
					3'b100: aluOp = ALU_XOR;
					3'b101: begin
						aluOp = instruction[30] ? ALU_SRA : ALU_SRL;
						rdWrite = funct7Valid;
					end
					3'b110: aluOp = ALU_OR;
					default: aluOp = ALU_AND;
				endcase
			end

			OPCODE_OP: begin
				// Bit 30 only legal on ADD/SUB and SRL/SRA
				rdWrite = funct7Valid && (!instruction[30] || (funct3 == 3'b000)
					|| (funct3 == 3'b101));
				case (funct3)
					3'b000: aluOp = instruction[30] ? ALU_SUB : ALU_ADD;
					3'b001: aluOp = ALU_SLL;
					3'b010: aluOp = ALU_SLT;
					3'b011: aluOp = ALU_SLTU;
					3'b100: aluOp = ALU_XOR;
					3'b101: aluOp = instruction[30] ? ALU_SRA : ALU_SRL;
					3'b110: aluOp = ALU_OR;
					default: aluOp = ALU_AND;
				endcase
			end

			OPCODE_LUI: begin
				aluOp = ALU_PASS_B;
				operandB = immediateU;
				rdWrite = 1'b1;
			end

			default: rdWrite = 1'b0;
		endcase
	end

endmodule

/* execute/integerAlu.sv */
`timescale 1ns/10ps

module integerAlu (
	input rv32Core_pkg::aluOp_t aluOp,
	input rv32Core_pkg::word_t operandA,
	input rv32Core_pkg::word_t operandB,
	output rv32Core_pkg::word_t result
);
	import rv32Core_pkg::*;

	logic [4:0] shiftAmount;

	// Shifts use the low five bits only
	assign shiftAmount = operandB[4:0];

	always_comb begin
		case (aluOp)
			ALU_ADD: result = operandA + operandB;
			ALU_SUB: result = operandA - operandB;
			ALU_SLL: result = operandA << shiftAmount;
			ALU_SLT: result = {31'b0, $signed(operandA) < $signed(operandB)};
			ALU_SLTU: result = {31'b0, operandA < operandB};
			ALU_XOR: result = operandA ^ operandB;
			ALU_SRL: result = operandA >> shiftAmount;
			ALU_SRA: result = word_t'($signed(operandA) >>> shiftAmount);
			ALU_OR: result = operandA | operandB;
			ALU_AND: result = operandA & operandB;
			ALU_PASS_B: result = operandB;
			default: result = '0;
		endcase
	end

endmodule

/* filelist.f */
common/rv32Core_pkg.sv
execute/integerAlu.sv
execute/instructionDecoder.sv
src/registerFile.sv
src/fetchControl.sv
src/managementPort.sv
src/rv32Core.sv
dv/rv32Core_checker.sv
dv/rv32Core_tb.sv

/* src/fetchControl.sv */
`timescale 1ns/10ps

module fetchControl #(
	parameter rv32Core_pkg::word_t resetVector = 32'h0000_0000
) (
	input logic clk,
	input logic rst,
	input logic allowInstruction,
	input logic pcSetStrobe,
	input rv32Core_pkg::word_t pcSetValue,
	input rv32Core_pkg::word_t instructionDataRead,
	input logic instructionBusy,
	output rv32Core_pkg::word_t instructionAddress,
	output logic instructionEnable,
	output rv32Core_pkg::word_t instruction,
	output rv32Core_pkg::word_t programCounter,
	output logic retire,
	output rv32Core_pkg::coreState_t state
);
	import rv32Core_pkg::*;

	word_t nextProgramCounter;

	assign nextProgramCounter = programCounter + 32'd4;

	// Fetch phase of execute, held through busy
	assign instructionEnable = (state == STATE_EXECUTE) && !retire;
	assign instructionAddress = programCounter;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= STATE_HALT;
			retire <= 1'b0;
			programCounter <= resetVector;
			instruction <= '0;
		end else begin
			retire <= 1'b0;
			case (state)
				STATE_HALT: begin
					if (pcSetStrobe) begin
						programCounter <= pcSetValue;
					end
					if (allowInstruction) begin
						state <= STATE_EXECUTE;
					end
				end

				STATE_EXECUTE: begin
					if (retire) begin
						programCounter <= nextProgramCounter;
						// Otherwise fetch the next one straight away
						if (!allowInstruction) begin
							state <= STATE_HALT;
						end
					end else if (!instructionBusy) begin
						instruction <= instructionDataRead;
						retire <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

/* src/managementPort.sv */
`timescale 1ns/10ps

module managementPort (
	input logic clk,
	input logic rst,
	input logic run,
	input logic writeEnable,
	input logic [3:0] byteSelect,
	input rv32Core_pkg::mgmtAddress_t address,
	input rv32Core_pkg::word_t writeData,
	input rv32Core_pkg::word_t programCounter,
	input rv32Core_pkg::word_t instruction,
	input logic retire,
	input rv32Core_pkg::word_t mgmtReadData,
	output rv32Core_pkg::word_t readData,
	output logic allowInstruction,
	output logic pcSetStrobe,
	output rv32Core_pkg::word_t pcSetValue,
	output rv32Core_pkg::regIndex_t mgmtIndex,
	output logic mgmtWriteStrobe,
	output rv32Core_pkg::word_t mgmtWriteData
);
	import rv32Core_pkg::*;

	mgmtRegion_t region;
	logic isSystem;
	logic selectPc;
	logic selectStep;
	logic selectInstruction;
	logic selectRegister;
	logic writeValid;
	logic readValid;
	logic stepStrobe;
	logic previousRun;
	logic stepPending;
	word_t dataOut;
	word_t byteMask;

	assign region = mgmtRegion_t'(address[15:14]);
	assign isSystem = region == REGION_SYSTEM;
	assign selectPc = isSystem && (address[13:0] == MGMT_PC_SET[13:0]);
	assign selectStep = isSystem && (address[13:0] == MGMT_PC_STEP[13:0]);
	assign selectInstruction = isSystem && (address[13:0] == MGMT_INSTRUCTION[13:0]);
	// 32 words above the register base
	assign selectRegister = (region == REGION_REGISTERS)
		&& (address[13:7] == MGMT_REGISTER_BASE[13:7]);

	// Host access only while the core is not running
	assign writeValid = !run && writeEnable;
	assign readValid = !run && !writeEnable;

	assign pcSetStrobe = writeValid && selectPc;
	assign pcSetValue = writeData;
	assign stepStrobe = writeValid && selectStep;

	assign mgmtIndex = regIndex_t'(address[6:2]);
	assign mgmtWriteStrobe = writeValid && selectRegister;
	assign mgmtWriteData = writeData;

	always_ff @(posedge clk) begin
		if (rst) begin
			previousRun <= 1'b0;
			stepPending <= 1'b0;
		end else begin
			previousRun <= run;
			if (stepStrobe) begin
				stepPending <= 1'b1;
			end else if (retire) begin
				stepPending <= 1'b0;
			end
		end
	end

	// A step releases exactly one instruction, so drop it in the retire cycle
	assign allowInstruction = (run && previousRun) || stepStrobe || (stepPending && !retire);

	always_comb begin
		dataOut = MGMT_UNMAPPED;
		if (readValid) begin
			if (selectPc) begin
				dataOut = programCounter;
			end else if (selectInstruction) begin
				dataOut = instruction;
			end else if (selectRegister) begin
				dataOut = mgmtReadData;
			end
		end
	end

	assign byteMask = {{8{byteSelect[3]}}, {8{byteSelect[2]}}, {8{byteSelect[1]}},
		{8{byteSelect[0]}}};
	assign readData = dataOut & byteMask;

endmodule

/* src/registerFile.sv */
`timescale 1ns/10ps

module registerFile (
	input logic clk,
	input logic rst,
	input rv32Core_pkg::regIndex_t rs1Index,
	input rv32Core_pkg::regIndex_t rs2Index,
	input rv32Core_pkg::regIndex_t rdIndex,
	input logic rdWrite,
	input logic retire,
	input rv32Core_pkg::word_t writeData,
	input rv32Core_pkg::regIndex_t mgmtIndex,
	input logic mgmtWriteStrobe,
	input rv32Core_pkg::word_t mgmtWriteData,
	output rv32Core_pkg::word_t rs1Data,
	output rv32Core_pkg::word_t rs2Data,
	output rv32Core_pkg::word_t mgmtReadData
);
	import rv32Core_pkg::*;

	word_t registers [0:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else begin
			if (mgmtWriteStrobe && (mgmtIndex != '0)) begin
				registers[mgmtIndex] <= mgmtWriteData;
			end
			// Core write lands on the retire edge
			if (retire && rdWrite && (rdIndex != '0)) begin
				registers[rdIndex] <= writeData;
			end
		end
	end

	assign rs1Data = (rs1Index == '0) ? '0 : registers[rs1Index];
	assign rs2Data = (rs2Index == '0) ? '0 : registers[rs2Index];
	assign mgmtReadData = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];

endmodule

/* src/rv32Core.sv */
`timescale 1ns/10ps

module rv32Core #(
	parameter rv32Core_pkg::word_t resetVector = 32'h0000_0000
) (
	input logic clk,
	input logic rst,

	input logic run,
	input logic writeEnable,
	input logic [3:0] byteSelect,
	input rv32Core_pkg::mgmtAddress_t address,
	input rv32Core_pkg::word_t writeData,
	output rv32Core_pkg::word_t readData,

	output rv32Core_pkg::word_t instructionAddress,
	output logic instructionEnable,
	input rv32Core_pkg::word_t instructionDataRead,
	input logic instructionBusy,

	output rv32Core_pkg::coreState_t probeState,
	output rv32Core_pkg::word_t probeProgramCounter
);
	import rv32Core_pkg::*;

	logic allowInstruction;
	logic pcSetStrobe;
	word_t pcSetValue;
	logic retire;
	word_t programCounter;
	word_t instruction;

	regIndex_t rs1Index;
	regIndex_t rs2Index;
	regIndex_t rdIndex;
	logic rdWrite;
	word_t rs1Data;
	word_t rs2Data;
	aluOp_t aluOp;
	word_t operandA;
	word_t operandB;
	word_t result;

	regIndex_t mgmtIndex;
	logic mgmtWriteStrobe;
	word_t mgmtWriteData;
	word_t mgmtReadData;

	assign probeProgramCounter = programCounter;

	managementPort managementPort0 (
		.clk(clk),
		.rst(rst),
		.run(run),
		.writeEnable(writeEnable),
		.byteSelect(byteSelect),
		.address(address),
		.writeData(writeData),
		.programCounter(programCounter),
		.instruction(instruction),
		.retire(retire),
		.mgmtReadData(mgmtReadData),
		.readData(readData),
		.allowInstruction(allowInstruction),
		.pcSetStrobe(pcSetStrobe),
		.pcSetValue(pcSetValue),
		.mgmtIndex(mgmtIndex),
		.mgmtWriteStrobe(mgmtWriteStrobe),
		.mgmtWriteData(mgmtWriteData)
	);

	fetchControl #(
		.resetVector(resetVector)
	) fetchControl0 (
		.clk(clk),
		.rst(rst),
		.allowInstruction(allowInstruction),
		.pcSetStrobe(pcSetStrobe),
		.pcSetValue(pcSetValue),
		.instructionDataRead(instructionDataRead),
		.instructionBusy(instructionBusy),
		.instructionAddress(instructionAddress),
		.instructionEnable(instructionEnable),
		.instruction(instruction),
		.programCounter(programCounter),
		.retire(retire),
		.state(probeState)
	);

	registerFile registerFile0 (
		.clk(clk),
		.rst(rst),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.rdIndex(rdIndex),
		.rdWrite(rdWrite),
		.retire(retire),
		.writeData(result),
		.mgmtIndex(mgmtIndex),
		.mgmtWriteStrobe(mgmtWriteStrobe),
		.mgmtWriteData(mgmtWriteData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtReadData(mgmtReadData)
	);

	instructionDecoder instructionDecoder0 (
		.instruction(instruction),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.rdIndex(rdIndex),
		.rdWrite(rdWrite),
		.aluOp(aluOp),
		.operandA(operandA),
		.operandB(operandB)
	);

	integerAlu integerAlu0 (
		.aluOp(aluOp),
		.operandA(operandA),
		.operandB(operandB),
		.result(result)
	);

endmodule
